// File: all.f
+incdir+design
design/riscv_pkg.sv
design/alu.sv
design/regfile.sv
design/instruction_decoder.sv
design/multicycle_datapath.sv
design/multicycle_control.sv
design/riscv_core.sv
test/riscv_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module riscv_core_tb -f all.f -o riscv_core_sim
./obj_dir/riscv_core_sim

// File: test/riscv_core_tb.sv
/*
 * Testbench for the multicycle RV32I core. Assembles a random program into a
 * word memory, runs an ISA model on a copy of it and checks every store.
 */

`default_nettype none

`include "riscv_config.svh"

module riscv_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] HALT_ADDRESS = 32'h0000_0ffc;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic        clock = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] mem_read_data;
    logic [31:0] mem_address;
    logic [31:0] mem_write_data;
    logic        mem_write_enable;

    logic [31:0] memory [1024];
    logic [31:0] ref_mem [1024];
    logic [31:0] ref_regs [32];
    logic [31:0] expected_address [$];
    logic [31:0] expected_data [$];
    logic [9:0]  emit_index;
    logic [11:0] result_offset;
    int          cycle_count = 0;
    int          cycle_limit = 100000;

    always #50 clock = ~clock;

    riscv_core DUT (
        .clock            (clock),
        .reset            (reset),
        .mem_read_data    (mem_read_data),
        .mem_address      (mem_address),
        .mem_write_data   (mem_write_data),
        .mem_write_enable (mem_write_enable)
    );

    assign mem_read_data = memory[mem_address[11:2]];

    always @(posedge clock) begin
        if (mem_write_enable) begin
            memory[mem_address[11:2]] = mem_write_data;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Errors found");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic logic [31:0] rtype(input logic [6:0] funct7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] funct3, input logic [4:0] rd,
                                          input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opcode);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // operand words sit at 0x800 upward and are reached from the 0x1000 base in x1
    function automatic logic [11:0] operand_offset(input int k);
        return 12'h800 + 12'(4 * k);
    endfunction

    task automatic emit(input logic [31:0] word);
        memory[emit_index] = word;
        emit_index = emit_index + 10'd1;
    endtask

    task automatic emit_load(input logic [4:0] rd, input logic [11:0] offset);
        emit(itype(offset, 5'd1, 3'b010, rd, OPC_LOAD));
    endtask

    task automatic store_result(input logic [4:0] rs2);
        emit(stype(result_offset, rs2, 5'd1));
        result_offset = result_offset + 12'd4;
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [11:0] imm;
        int          pair_a [3];
        int          pair_b [3];
        emit_index = 10'd0;
        result_offset = 12'hc00;
        for (int k = 0; k < 8; k++) begin
            memory[10'(512 + k)] = $urandom();
        end
        memory[10'd512] = memory[10'd512] | 32'h8000_0000;
        memory[10'd518] = memory[10'd518] | 32'h8000_0000;
        memory[10'd519] = memory[10'd519] & 32'h7fff_ffff;
        emit(utype(20'h00001, 5'd1, OPC_LUI));
        for (int t = 0; t < 3; t++) begin
            emit_load(5'd2, operand_offset(2 * t));
            emit_load(5'd3, operand_offset(2 * t + 1));
            for (int f = 0; f < 8; f++) begin
                emit(rtype(7'h00, 5'd3, 5'd2, 3'(f), 5'd4));
                store_result(5'd4);
            end
            emit(rtype(7'h20, 5'd3, 5'd2, 3'b000, 5'd4));
            store_result(5'd4);
            emit(rtype(7'h20, 5'd3, 5'd2, 3'b101, 5'd4));
            store_result(5'd4);
            for (int f = 0; f < 8; f++) begin
                r = $urandom();
                imm = (f == 1 || f == 5) ? {7'h00, r[4:0]} : r[11:0];
                emit(itype(imm, 5'd2, 3'(f), 5'd5, OPC_OP_IMM));
                store_result(5'd5);
            end
            r = $urandom();
            emit(itype({7'h20, r[4:0]}, 5'd2, 3'b101, 5'd5, OPC_OP_IMM));
            store_result(5'd5);
        end
        // read back the first result and a preloaded word
        emit_load(5'd13, 12'hc00);
        store_result(5'd13);
        emit_load(5'd13, operand_offset(6));
        store_result(5'd13);
        r = $urandom();
        emit(utype(r[31:12], 5'd6, OPC_LUI));
        store_result(5'd6);
        r = $urandom();
        emit(utype(r[31:12], 5'd7, OPC_AUIPC));
        store_result(5'd7);
        // equal, negative against positive, positive against negative
        pair_a = '{6, 6, 7};
        pair_b = '{6, 7, 6};
        for (int p = 0; p < 3; p++) begin
            emit_load(5'd2, operand_offset(pair_a[p]));
            emit_load(5'd3, operand_offset(pair_b[p]));
            for (int f = 0; f < 8; f++) begin
                if (f != 2 && f != 3) begin
                    emit(btype(13'd12, 5'd3, 5'd2, 3'(f)));
                    emit(itype(12'(32'h100 + p * 16 + f), 5'd0, 3'b000, 5'd8, OPC_OP_IMM));
                    emit(jtype(21'd8, 5'd0));
                    emit(itype(12'(32'h200 + p * 16 + f), 5'd0, 3'b000, 5'd8, OPC_OP_IMM));
                    store_result(5'd8);
                end
            end
        end
        emit(jtype(21'd8, 5'd9));
        emit(itype(12'h7ff, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
        store_result(5'd9);
        // odd jalr offset so bit 0 of the target has to drop
        emit(utype(20'h00000, 5'd11, OPC_AUIPC));
        emit(itype(12'd13, 5'd11, 3'b000, 5'd12, OPC_JALR));
        emit(itype(12'h055, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
        // the jalr target records its own pc through auipc
        emit(utype(20'h00000, 5'd14, OPC_AUIPC));
        store_result(5'd12);
        store_result(5'd10);
        store_result(5'd11);
        store_result(5'd14);
        emit(stype(12'hffc, 5'd2, 5'd1));
        emit(jtype(21'd0, 5'd0));
    endtask

    function automatic logic [31:0] arith_result(input logic [2:0] funct3, input logic alternate,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] signed_a;
        logic [31:0]        result;
        signed_a = a;
        case (funct3)
            3'b000: result = alternate ? a - b : a + b;
            3'b001: result = a << b[4:0];
            3'b010: result = {31'd0, $signed(a) < $signed(b)};
            3'b011: result = {31'd0, a < b};
            3'b100: result = a ^ b;
            3'b101: begin
                if (alternate) begin
                    result = signed_a >>> b[4:0];
                end else begin
                    result = a >> b[4:0];
                end
            end
            3'b110: result = a | b;
            default: result = a & b;
        endcase
        return result;
    endfunction

    // runs one instruction on the model state and returns the next pc
    function automatic logic [31:0] reference_step(input logic [31:0] pc);
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] address;
        logic [31:0] next_pc;
        logic [31:0] result;
        logic        write_rd;
        logic        taken;
        inst = ref_mem[pc[11:2]];
        a = ref_regs[inst[19:15]];
        b = ref_regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {inst[31:12], 12'd0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        next_pc = pc + 32'd4;
        result = 32'd0;
        address = 32'd0;
        write_rd = 1'b1;
        taken = 1'b0;
        case (inst[6:0])
            OPC_LUI:   result = imm_u;
            OPC_AUIPC: result = pc + imm_u;
            OPC_JAL: begin
                result = pc + 32'd4;
                next_pc = pc + imm_j;
            end
            OPC_JALR: begin
                result = pc + 32'd4;
                next_pc = (a + imm_i) & 32'hffff_fffe;
            end
            OPC_BRANCH: begin
                write_rd = 1'b0;
                case (inst[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    next_pc = pc + imm_b;
                end
            end
            OPC_LOAD: begin
                address = a + imm_i;
                result = ref_mem[address[11:2]];
            end
            OPC_STORE: begin
                write_rd = 1'b0;
                address = a + imm_s;
                ref_mem[address[11:2]] = b;
                expected_address.push_back(address);
                expected_data.push_back(b);
            end
            OPC_OP_IMM: result = arith_result(inst[14:12], inst[14:12] == 3'b101 && inst[30],
                                              a, imm_i);
            OPC_OP:     result = arith_result(inst[14:12], inst[30], a, b);
            default:    write_rd = 1'b0;
        endcase
        if (write_rd && inst[11:7] != 5'd0) begin
            ref_regs[inst[11:7]] = result;
        end
        return next_pc;
    endfunction

    initial begin
        logic [31:0] pc;
        int          instruction_count;
        logic        halted;
        void'($urandom(32'hcb7f));
        for (int i = 0; i < 1024; i++) begin
            memory[10'(i)] = {20'hbad00, 10'(i), 2'b00};
        end
        build_program();
        ref_mem = memory;
        for (int i = 0; i < 32; i++) begin
            ref_regs[5'(i)] = 32'd0;
        end
        pc = `INITIAL_PC;
        instruction_count = 0;
        halted = 1'b0;
        while (!halted && instruction_count < 2000) begin
            pc = reference_step(pc);
            instruction_count++;
            halted = expected_address.size() > 0 && expected_address[$] == HALT_ADDRESS;
        end
        if (!halted) begin
            abort_run("reference model never reached the halt store");
        end
        cycle_limit = 6 * instruction_count + 100;
        repeat (8) begin
            @(negedge clock);
            check_value("mem_write_enable", {31'd0, mem_write_enable}, 32'd0);
        end
        reset = 1'b0;
        check_value("mem_address", mem_address, `INITIAL_PC);
    end

    // store checker
    always @(negedge clock) begin
        logic [31:0] want_address;
        logic [31:0] want_data;
        if (mem_write_enable) begin
            if (expected_address.size() == 0) begin
                abort_run("store seen after the expected store list was used up");
            end else begin
                want_address = expected_address.pop_front();
                want_data = expected_data.pop_front();
                check_value("mem_address", mem_address, want_address);
                check_value("mem_write_data", mem_write_data, want_data);
                if (want_address == HALT_ADDRESS) begin
                    if (expected_address.size() == 0) begin
                        $display("No errors");
                        $finish;
                    end else begin
                        abort_run("halt store came before all expected stores");
                    end
                end else if (expected_address.size() == 0) begin
                    abort_run("expected store list used up without the halt store");
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run("timeout, the halt store never arrived");
        end
    end

endmodule

`default_nettype wire

// File: design/riscv_core.sv
/*
 * Top of the multicycle RV32I core. Connects control and datapath to a
 * single memory port with combinational read and a write strobe.
 */

`default_nettype none

module riscv_core import riscv_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] mem_read_data,
    output logic [31:0] mem_address,
    output logic [31:0] mem_write_data,
    output logic        mem_write_enable
);

    datapath_control_t control;
    datapath_status_t  status;

    multicycle_datapath multicycle_datapath (
        .clock          (clock),
        .reset          (reset),
        .control        (control),
        .status         (status),
        .mem_read_data  (mem_read_data),
        .mem_address    (mem_address),
        .mem_write_data (mem_write_data)
    );

    multicycle_control multicycle_control (
        .clock            (clock),
        .reset            (reset),
        .status           (status),
        .control          (control),
        .mem_write_enable (mem_write_enable)
    );

endmodule

`default_nettype wire

// File: design/multicycle_control.sv
/*
 * Five-state FSM that sequences the multicycle datapath through fetch,
 * decode, execute, memory and writeback, and resolves branches.
 */

`default_nettype none

module multicycle_control import riscv_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  datapath_status_t  status,
    output datapath_control_t control,
    output logic              mem_write_enable
);

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } state_t;

    state_t        state;
    state_t        next_state;
    opcode_t       opcode;
    logic [2:0]    funct3;
    logic          funct7_bit5;
    alu_function_t arith_function;
    alu_function_t branch_function;
    logic          branch_taken;

    assign opcode      = status.fields.opcode;
    assign funct3      = status.fields.funct3;
    assign funct7_bit5 = status.fields.funct7[5];

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            FETCH: next_state = DECODE;
            DECODE: begin
                case (opcode)
                    OPCODE_JAL,
                    OPCODE_LUI:    next_state = WRITEBACK;
                    OPCODE_AUIPC,
                    OPCODE_JALR,
                    OPCODE_BRANCH,
                    OPCODE_LOAD,
                    OPCODE_STORE,
                    OPCODE_OP_IMM,
                    OPCODE_OP:     next_state = EXECUTE;
                    // unsupported opcode acts as a nop
                    default:       next_state = FETCH;
                endcase
            end
            EXECUTE: begin
                case (opcode)
                    OPCODE_BRANCH: next_state = FETCH;
                    OPCODE_LOAD,
                    OPCODE_STORE:  next_state = MEMORY;
                    default:       next_state = WRITEBACK;
                endcase
            end
            MEMORY:  next_state = (opcode == OPCODE_LOAD) ? WRITEBACK : FETCH;
            default: next_state = FETCH;
        endcase
    end

    // sub only for register form, sra/srai both use funct7 bit 5
    always_comb begin
        case (funct3)
            3'b000:  arith_function = (opcode == OPCODE_OP && funct7_bit5) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_function = ALU_SLL;
            3'b010:  arith_function = ALU_SLT;
            3'b011:  arith_function = ALU_SLTU;
            3'b100:  arith_function = ALU_XOR;
            3'b101:  arith_function = funct7_bit5 ? ALU_SRA : ALU_SRL;
            3'b110:  arith_function = ALU_OR;
            default: arith_function = ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3[2:1])
            2'b10:   branch_function = ALU_SLT;
            2'b11:   branch_function = ALU_SLTU;
            default: branch_function = ALU_SUB;
        endcase
    end

    // eq tests on a zero difference, lt on a nonzero slt; funct3[0] negates
    assign branch_taken = (funct3[2] ? !status.alu_result_equal_zero
                                     : status.alu_result_equal_zero) ^ funct3[0];

    always_comb begin
        control.alu_function         = ALU_ADD;
        control.operand_a_sel        = A_RS1;
        control.operand_b_sel        = B_RS2;
        control.next_pc_sel          = NEXT_PC_ALU_RESULT;
        control.writeback_sel        = WB_ALU_OUT;
        control.pc_write_enable      = 1'b0;
        control.last_pc_write_enable = 1'b0;
        control.alu_out_write_enable = 1'b0;
        control.inst_write_enable    = 1'b0;
        control.data_write_enable    = 1'b0;
        control.regfile_write_enable = 1'b0;
        control.inst_or_data         = 1'b0;
        mem_write_enable             = 1'b0;

        case (state)
            FETCH: begin
                // pc+4 goes to pc and also to alu_out as the link value
                control.operand_a_sel        = A_PC;
                control.operand_b_sel        = B_FOUR;
                control.pc_write_enable      = 1'b1;
                control.last_pc_write_enable = 1'b1;
                control.inst_write_enable    = 1'b1;
                control.alu_out_write_enable = 1'b1;
            end
            DECODE: begin
                control.operand_a_sel = A_LAST_PC;
                control.operand_b_sel = B_IMM;
                // jumps keep the link from fetch
                control.alu_out_write_enable = !(opcode == OPCODE_JAL || opcode == OPCODE_JALR);
                control.pc_write_enable      = (opcode == OPCODE_JAL);
            end
            EXECUTE: begin
                control.alu_out_write_enable = 1'b1;
                case (opcode)
                    OPCODE_OP: begin
                        control.alu_function = arith_function;
                    end
                    OPCODE_OP_IMM: begin
                        control.alu_function  = arith_function;
                        control.operand_b_sel = B_IMM;
                    end
                    OPCODE_AUIPC: begin
                        control.operand_a_sel = A_LAST_PC;
                        control.operand_b_sel = B_IMM;
                    end
                    OPCODE_JALR: begin
                        control.operand_b_sel        = B_IMM;
                        control.alu_out_write_enable = 1'b0;
                        control.pc_write_enable      = 1'b1;
                    end
                    OPCODE_BRANCH: begin
                        control.alu_function         = branch_function;
                        control.next_pc_sel          = NEXT_PC_ALU_OUT;
                        control.alu_out_write_enable = 1'b0;
                        control.pc_write_enable      = branch_taken;
                    end
                    default: begin
                        // load/store effective address
                        control.operand_b_sel = B_IMM;
                    end
                endcase
            end
            MEMORY: begin
                control.inst_or_data      = 1'b1;
                control.data_write_enable = (opcode == OPCODE_LOAD);
                mem_write_enable          = (opcode == OPCODE_STORE);
            end
            default: begin
                control.regfile_write_enable = 1'b1;
                if (opcode == OPCODE_LUI) begin
                    control.writeback_sel = WB_IMM;
                end else if (opcode == OPCODE_LOAD) begin
                    control.writeback_sel = WB_DATA;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/multicycle_datapath.sv
/*
 * Datapath of the multicycle core: architectural and holding registers,
 * operand and next-PC selection, ALU and register file. Driven by the control.
 */

`default_nettype none

`include "riscv_config.svh"

module multicycle_datapath import riscv_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  datapath_control_t control,
    output datapath_status_t  status,
    input  logic [`XLEN-1:0]  mem_read_data,
    output logic [`XLEN-1:0]  mem_address,
    output logic [`XLEN-1:0]  mem_write_data
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] last_pc;
    logic [`XLEN-1:0] inst;
    logic [`XLEN-1:0] data;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] rs1_out;
    logic [`XLEN-1:0] rs2_out;

    logic [`XLEN-1:0] immediate;
    logic [`XLEN-1:0] alu_operand_a;
    logic [`XLEN-1:0] alu_operand_b;
    logic [`XLEN-1:0] alu_result;
    logic             alu_zero;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] rd_data;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    inst_fields_t     inst_fields;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc      <= `INITIAL_PC;
            last_pc <= `INITIAL_PC;
        end else begin
            if (control.pc_write_enable) begin
                pc <= next_pc;
            end
            if (control.last_pc_write_enable) begin
                last_pc <= pc;
            end
        end
    end

    // holding registers
    always_ff @(posedge clock) begin
        if (control.inst_write_enable) begin
            inst <= mem_read_data;
        end
        if (control.data_write_enable) begin
            data <= mem_read_data;
        end
        if (control.alu_out_write_enable) begin
            alu_out <= alu_result;
        end
        rs1_out <= rs1_data;
        rs2_out <= rs2_data;
    end

    always_comb begin
        case (control.operand_a_sel)
            A_RS1:     alu_operand_a = rs1_out;
            A_PC:      alu_operand_a = pc;
            A_LAST_PC: alu_operand_a = last_pc;
            default:   alu_operand_a = '0;
        endcase
    end

    always_comb begin
        case (control.operand_b_sel)
            B_RS2:   alu_operand_b = rs2_out;
            B_IMM:   alu_operand_b = immediate;
            default: alu_operand_b = 32'd4;
        endcase
    end

    // jalr needs bit 0 cleared, every other target is already even
    always_comb begin
        case (control.next_pc_sel)
            NEXT_PC_ALU_OUT: next_pc = {alu_out[`XLEN-1:1], 1'b0};
            default:         next_pc = {alu_result[`XLEN-1:1], 1'b0};
        endcase
    end

    always_comb begin
        case (control.writeback_sel)
            WB_DATA: rd_data = data;
            WB_IMM:  rd_data = immediate;
            default: rd_data = alu_out;
        endcase
    end

    assign mem_address    = control.inst_or_data ? alu_out : pc;
    assign mem_write_data = rs2_out;

    assign status = '{fields: inst_fields, alu_result_equal_zero: alu_zero};

    instruction_decoder instruction_decoder (
        .inst      (inst),
        .fields    (inst_fields),
        .immediate (immediate)
    );

    alu alu (
        .alu_function      (control.alu_function),
        .operand_a         (alu_operand_a),
        .operand_b         (alu_operand_b),
        .result            (alu_result),
        .result_equal_zero (alu_zero)
    );

    regfile regfile (
        .clock        (clock),
        .reset        (reset),
        .write_enable (control.regfile_write_enable),
        .rd_address   (inst_fields.rd),
        .rs1_address  (inst_fields.rs1),
        .rs2_address  (inst_fields.rs2),
        .rd_data      (rd_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

endmodule

`default_nettype wire

// File: design/instruction_decoder.sv
/*
 * Splits an RV32I instruction into its fields and forms the sign-extended
 * immediate, choosing the format from the instruction's own opcode.
 */

`default_nettype none

module instruction_decoder import riscv_pkg::*; (
    input  logic [31:0]  inst,
    output inst_fields_t fields,
    output logic [31:0]  immediate
);

    opcode_t opcode;

    assign opcode = opcode_t'(inst[6:0]);

    assign fields.opcode = opcode;
    assign fields.rd     = inst[11:7];
    assign fields.funct3 = inst[14:12];
    assign fields.rs1    = inst[19:15];
    assign fields.rs2    = inst[24:20];
    assign fields.funct7 = inst[31:25];

    always_comb begin
        case (opcode)
            // i-type
            OPCODE_JALR,
            OPCODE_LOAD,
            OPCODE_OP_IMM: begin
                immediate = {{21{inst[31]}}, inst[30:20]};
            end
            OPCODE_STORE: begin
                immediate = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            end
            OPCODE_BRANCH: begin
                immediate = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            // u-type
            OPCODE_LUI,
            OPCODE_AUIPC: begin
                immediate = {inst[31:12], 12'b0};
            end
            OPCODE_JAL: begin
                immediate = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                immediate = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/regfile.sv
/*
 * 32-entry integer register file, two asynchronous reads and one clocked write.
 */

`default_nettype none

`include "riscv_config.svh"

module regfile (
    input  logic              clock,
    input  logic              reset,
    input  logic              write_enable,
    input  logic [4:0]        rd_address,
    input  logic [4:0]        rs1_address,
    input  logic [4:0]        rs2_address,
    input  logic [`XLEN-1:0]  rd_data,
    output logic [`XLEN-1:0]  rs1_data,
    output logic [`XLEN-1:0]  rs2_data
);

    logic [`XLEN-1:0] registers [32];

    // x0 is never written, so it reads back as zero
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable && rd_address != 5'd0) begin
            registers[rd_address] <= rd_data;
        end
    end

    assign rs1_data = registers[rs1_address];
    assign rs2_data = registers[rs2_address];

endmodule

`default_nettype wire

// File: design/alu.sv
/*
 * Combinational RV32I ALU. The zero flag feeds branch decisions in the control.
 */

`default_nettype none

`include "riscv_config.svh"

module alu import riscv_pkg::*; (
    input  alu_function_t     alu_function,
    input  logic [`XLEN-1:0]  operand_a,
    input  logic [`XLEN-1:0]  operand_b,
    output logic [`XLEN-1:0]  result,
    output logic              result_equal_zero
);

    logic [4:0] shift_amount;

    // only the low five bits count for shifts
    assign shift_amount = operand_b[4:0];

    always_comb begin
        case (alu_function)
            ALU_ADD:  result = operand_a + operand_b;
            ALU_SUB:  result = operand_a - operand_b;
            ALU_SLL:  result = operand_a << shift_amount;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, operand_a < operand_b};
            ALU_XOR:  result = operand_a ^ operand_b;
            ALU_SRL:  result = operand_a >> shift_amount;
            ALU_SRA:  result = $unsigned($signed(operand_a) >>> shift_amount);
            ALU_OR:   result = operand_a | operand_b;
            ALU_AND:  result = operand_a & operand_b;
            default:  result = '0;
        endcase
    end

    assign result_equal_zero = (result == '0);

endmodule

`default_nettype wire

// File: design/riscv_pkg.sv
/*
 * Types shared by the control and datapath of the multicycle RV32I core.
 */

`default_nettype none

package riscv_pkg;

    typedef enum logic [6:0] {
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011
    } opcode_t;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_SLL  = 5'd2,
        ALU_SLT  = 5'd3,
        ALU_SLTU = 5'd4,
        ALU_XOR  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_OR   = 5'd8,
        ALU_AND  = 5'd9
    } alu_function_t;

    typedef enum logic [1:0] {
        A_RS1     = 2'd0,
        A_PC      = 2'd1,
        A_LAST_PC = 2'd2,
        A_ZERO    = 2'd3
    } operand_a_sel_t;

    typedef enum logic [1:0] {
        B_RS2  = 2'd0,
        B_IMM  = 2'd1,
        B_FOUR = 2'd2
    } operand_b_sel_t;

    typedef enum logic [1:0] {
        NEXT_PC_ALU_RESULT = 2'd0,
        NEXT_PC_ALU_OUT    = 2'd1
    } next_pc_sel_t;

    typedef enum logic [1:0] {
        WB_ALU_OUT = 2'd0,
        WB_DATA    = 2'd1,
        WB_IMM     = 2'd2
    } writeback_sel_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
    } inst_fields_t;

    typedef struct packed {
        alu_function_t  alu_function;
        operand_a_sel_t operand_a_sel;
        operand_b_sel_t operand_b_sel;
        next_pc_sel_t   next_pc_sel;
        writeback_sel_t writeback_sel;
        logic           pc_write_enable;
        logic           last_pc_write_enable;
        logic           alu_out_write_enable;
        logic           inst_write_enable;
        logic           data_write_enable;
        logic           regfile_write_enable;
        logic           inst_or_data;
    } datapath_control_t;

    typedef struct packed {
        inst_fields_t fields;
        logic         alu_result_equal_zero;
    } datapath_status_t;

endpackage

`default_nettype wire

// File: design/riscv_config.svh
/*
 * Build-time constants for the RV32I core: reset vector and data width.
 * Include in any design file that needs them.
 */

`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// first fetch address after reset
`define INITIAL_PC 32'h0000_0000

// register and data width
`define XLEN 32

`endif
